//--- sim.f
+incdir+.
clint_pkg.sv
clint_tick_gen.sv
clint_timer.sv
clint_apb_slave.sv
clint_top.sv
clint_assert.sv
tb_clint.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_clint
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_clint.sv
/*
 * Testbench of the core-local interrupt block:
 *   clock, reset and cycle watchdog,
 *   APB transfer tasks driven on the falling edge,
 *   LFSR data source, reference byte reversal,
 *   reset, read-back, counting, interrupt and unmapped access checks
 */
`include "clint_config.svh"

module tb_clint import clint_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CYCLE_LIMIT = 3000;

	logic        clk;
	logic        rst;
	apb_req_t    req;
	apb_rsp_t    rsp;
	logic        irq;
	logic        s_irq;
	logic [31:0] lfsr_state = 32'hd7d3;
	int          cycles = 0;
	int          irq_cnt = 0;

	clint_top i_clint_top (
		.clk     (clk),
		.rst     (rst),
		.apb_req (req),
		.apb_rsp (rsp),
		.irq     (irq),
		.s_irq   (s_irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// timer interrupt pulses, counted where irq is stable
	always @(negedge clk) begin
		if (irq) begin
			irq_cnt <= irq_cnt + 1;
		end
	end

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped after a failed check");
	endtask

	// watchdog and bound assertion monitor
	always @(negedge clk) begin
		cycles <= cycles + 1;
		if (i_clint_top.i_clint_assert.err_cnt != 0) begin
			$display("a concurrent assertion on the DUT ports failed");
			abort_run();
		end else if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: sequence still running after %0d cycles", CYCLE_LIMIT);
			abort_run();
		end
	end

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit taken
	task automatic random_word(output word_t w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			w = {w[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// bus order to register order and back
	function automatic word_t byte_reverse(input word_t w);
		word_t r;
		r = {<<8{w}};
		return r;
	endfunction

	task automatic verify(input string name, input word_t exp, input word_t got);
		assert (got === exp) else begin
			$display("[ERROR] %s expected %h got %h", name, exp, got);
			abort_run();
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// setup then access, response sampled mid access phase
	task automatic apb_transfer(input logic write, input ofs_t addr, input word_t wdata,
			output word_t rdata, output logic err);
		@(negedge clk);
		req.psel    = 1'b1;
		req.penable = 1'b0;
		req.pwrite  = write;
		req.paddr   = addr;
		req.pwdata  = wdata;
		@(negedge clk);
		req.penable = 1'b1;
		#1;
		rdata = rsp.prdata;
		err   = rsp.pslverr;
		@(negedge clk);
		req.psel    = 1'b0;
		req.penable = 1'b0;
		req.pwrite  = 1'b0;
	endtask

	task automatic apb_write(input ofs_t addr, input word_t data);
		word_t rdata;
		logic  err;
		apb_transfer(1'b1, addr, data, rdata, err);
		verify("pslverr", 32'd0, {31'd0, err});
	endtask

	task automatic apb_read(input ofs_t addr, output word_t data);
		logic err;
		apb_transfer(1'b0, addr, '0, data, err);
		verify("pslverr", 32'd0, {31'd0, err});
	endtask

	initial begin
		word_t rd;
		word_t a;
		word_t b;
		word_t lo_reg;
		logic  err;
		time_t now_t;
		time_t target;
		int    base;

		rst = 1'b1;
		req = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// reset values
		apb_read(`CLINT_CMPL_OFS, rd);
		verify("mtimecmp lo", 32'hFFFF_FFFF, rd);
		apb_read(`CLINT_CMPH_OFS, rd);
		verify("mtimecmp hi", 32'hFFFF_FFFF, rd);
		apb_read(`CLINT_MSIP_OFS, rd);
		verify("msip", 32'd0, rd);
		verify("irq", 32'd0, {31'd0, irq});
		verify("s_irq", 32'd0, {31'd0, s_irq});

		// read-back through the swap on both paths
		random_word(a);
		random_word(b);
		apb_write(`CLINT_CMPL_OFS, a);
		apb_write(`CLINT_CMPH_OFS, b);
		apb_read(`CLINT_CMPL_OFS, rd);
		verify("mtimecmp lo", a, rd);
		apb_read(`CLINT_CMPH_OFS, rd);
		verify("mtimecmp hi", b, rd);
		apb_write(`CLINT_MSIP_OFS, 32'h0000_0001);
		verify("s_irq", 32'd1, {31'd0, s_irq});
		apb_read(`CLINT_MSIP_OFS, rd);
		verify("msip", 32'h0000_0001, rd);
		apb_write(`CLINT_MSIP_OFS, 32'h0000_0000);
		verify("s_irq", 32'd0, {31'd0, s_irq});

		// carry from the low word, about 35 ticks in 206 cycles
		apb_write(`CLINT_MTIMEL_OFS, byte_reverse(32'hFFFF_FFF0));
		apb_write(`CLINT_MTIMEH_OFS, 32'd0);
		wait_cycles(200);
		apb_read(`CLINT_MTIMEH_OFS, rd);
		verify("mtime hi", byte_reverse(32'd1), rd);
		apb_read(`CLINT_MTIMEL_OFS, rd);
		lo_reg = byte_reverse(rd);
		assert (lo_reg >= 32'd16 && lo_reg <= 32'd40) else begin
			$display("[ERROR] mtime lo %h outside %h..%h", lo_reg, 32'd16, 32'd40);
			abort_run();
		end

		// compare five ticks ahead, high word parked out of reach first
		apb_read(`CLINT_MTIMEL_OFS, rd);
		now_t[31:0] = byte_reverse(rd);
		apb_read(`CLINT_MTIMEH_OFS, rd);
		now_t[63:32] = byte_reverse(rd);
		target = now_t + 64'd5;
		apb_write(`CLINT_CMPH_OFS, 32'hFFFF_FFFF);
		apb_write(`CLINT_CMPL_OFS, byte_reverse(target[31:0]));
		apb_write(`CLINT_CMPH_OFS, byte_reverse(target[63:32]));
		base = irq_cnt;
		wait_cycles(60);
		verify("irq pulse count", 32'd1, word_t'(irq_cnt - base));
		wait_cycles(100);
		verify("irq pulse count", 32'd1, word_t'(irq_cnt - base));

		// re-arm with the compare already passed
		base = irq_cnt;
		apb_write(`CLINT_CMPH_OFS, byte_reverse(target[63:32]));
		wait_cycles(20);
		verify("irq pulse count", 32'd1, word_t'(irq_cnt - base));

		// unmapped offset, no state change and no arming
		base = irq_cnt;
		random_word(a);
		apb_transfer(1'b1, 16'h1234, a, rd, err);
		verify("pslverr", 32'd1, {31'd0, err});
		verify("prdata", 32'd0, rd);
		apb_transfer(1'b0, 16'h1234, '0, rd, err);
		verify("pslverr", 32'd1, {31'd0, err});
		verify("prdata", 32'd0, rd);
		apb_read(`CLINT_CMPL_OFS, rd);
		verify("mtimecmp lo", byte_reverse(target[31:0]), rd);
		apb_read(`CLINT_CMPH_OFS, rd);
		verify("mtimecmp hi", byte_reverse(target[63:32]), rd);
		wait_cycles(30);
		verify("irq pulse count", 32'd0, word_t'(irq_cnt - base));

		if (i_clint_top.i_clint_assert.err_cnt == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("a concurrent assertion on the DUT ports failed");
			abort_run();
		end
	end

endmodule

//--- clint_assert.sv
/*
 * Port assertions of the interrupt block top level:
 *   pready in every access phase,
 *   single-cycle timer interrupt pulse,
 *   quiet outputs right after reset,
 *   pslverr confined to the access phase
 */
module clint_assert import clint_pkg::*; (
	input logic     clk,
	input logic     rst,
	input apb_req_t apb_req,
	input apb_rsp_t apb_rsp,
	input logic     irq,
	input logic     s_irq
);
	timeunit 1ns;
	timeprecision 1ps;

	// count of failed assertions
	int err_cnt = 0;

	// zero wait states in every access phase
	assert property (@(posedge clk) disable iff (rst)
		(apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
	else begin
		$error("pready low during an access phase");
		err_cnt = err_cnt + 1;
	end

	assert property (@(posedge clk) disable iff (rst) irq |=> !irq)
	else begin
		$error("irq high for two cycles in a row");
		err_cnt = err_cnt + 1;
	end

	// first cycle out of reset
	assert property (@(posedge clk) $fell(rst) |-> (!irq && !s_irq && !apb_rsp.pslverr))
	else begin
		$error("irq, s_irq or pslverr high right after reset");
		err_cnt = err_cnt + 1;
	end

	assert property (@(posedge clk) disable iff (rst)
		apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
	else begin
		$error("pslverr high outside an access phase");
		err_cnt = err_cnt + 1;
	end

endmodule

bind clint_top clint_assert i_clint_assert (
	.clk     (clk),
	.rst     (rst),
	.apb_req (apb_req),
	.apb_rsp (apb_rsp),
	.irq     (irq),
	.s_irq   (s_irq)
);

//--- clint_top.sv
/*
 * Top level of the core-local interrupt block.
 * Connects the APB slave, the tick prescaler and the timer core.
 */
module clint_top import clint_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	output logic     irq,
	output logic     s_irq
);

	logic      tick;
	reg_wr_t   reg_wr;
	reg_view_t reg_view;

	// bus side
	clint_apb_slave i_clint_apb_slave (
		.clk  (clk),
		.rst  (rst),
		.req  (apb_req),
		.rsp  (apb_rsp),
		.wr   (reg_wr),
		.view (reg_view)
	);

	// timer rate
	clint_tick_gen i_clint_tick_gen (
		.clk  (clk),
		.rst  (rst),
		.tick (tick)
	);

	// registers and interrupts
	clint_timer i_clint_timer (
		.clk   (clk),
		.rst   (rst),
		.tick  (tick),
		.wr    (reg_wr),
		.view  (reg_view),
		.irq   (irq),
		.s_irq (s_irq)
	);

endmodule

//--- clint_apb_slave.sv
/*
 * Zero-wait-state APB slave of the interrupt block:
 *   setup tracking and access phase detection,
 *   offset decode and one-hot write strobes,
 *   byte swap on write data and read data,
 *   read multiplexer, pready and pslverr
 */
`include "clint_config.svh"

module clint_apb_slave import clint_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  apb_req_t  req,
	output apb_rsp_t  rsp,
	output reg_wr_t   wr,
	input  reg_view_t view
);

	logic  in_setup;
	logic  access;
	logic  wr_access;
	logic  rd_access;
	logic  sel_msip;
	logic  sel_cmp_lo;
	logic  sel_cmp_hi;
	logic  sel_time_lo;
	logic  sel_time_hi;
	logic  mapped;
	word_t rd_word;

	// bus and registers differ in byte order
	function automatic word_t bswap(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// remember the setup phase so an access is taken once per transfer
	always_ff @(posedge clk) begin
		if (rst) begin
			in_setup <= 1'b0;
		end else begin
			in_setup <= req.psel & ~req.penable;
		end
	end

	assign access    = req.psel & req.penable & in_setup;
	assign wr_access = access & req.pwrite;
	assign rd_access = access & ~req.pwrite;

	// offset decode
	assign sel_msip    = (req.paddr == `CLINT_MSIP_OFS);
	assign sel_cmp_lo  = (req.paddr == `CLINT_CMPL_OFS);
	assign sel_cmp_hi  = (req.paddr == `CLINT_CMPH_OFS);
	assign sel_time_lo = (req.paddr == `CLINT_MTIMEL_OFS);
	assign sel_time_hi = (req.paddr == `CLINT_MTIMEH_OFS);

	assign mapped = sel_msip | sel_cmp_lo | sel_cmp_hi | sel_time_lo | sel_time_hi;

	// write strobes, at most one per access
	assign wr.msip    = wr_access & sel_msip;
	assign wr.cmp_lo  = wr_access & sel_cmp_lo;
	assign wr.cmp_hi  = wr_access & sel_cmp_hi;
	assign wr.time_lo = wr_access & sel_time_lo;
	assign wr.time_hi = wr_access & sel_time_hi;
	assign wr.data    = bswap(req.pwdata);

	// read mux in register byte order, unmapped reads zero
	always_comb begin
		rd_word = '0;
		case (req.paddr)
			`CLINT_MSIP_OFS: begin
				rd_word[`CLINT_MSIP_BIT] = view.msip;
			end
			`CLINT_CMPL_OFS: begin
				rd_word = view.mtimecmp[31:0];
			end
			`CLINT_CMPH_OFS: begin
				rd_word = view.mtimecmp[63:32];
			end
			`CLINT_MTIMEL_OFS: begin
				rd_word = view.mtime[31:0];
			end
			`CLINT_MTIMEH_OFS: begin
				rd_word = view.mtime[63:32];
			end
			default: begin
				rd_word = '0;
			end
		endcase
	end

	// response, data only in a read access
	assign rsp.prdata  = rd_access ? bswap(rd_word) : '0;
	assign rsp.pready  = access;
	assign rsp.pslverr = access & ~mapped;

endmodule

//--- clint_timer.sv
/*
 * Timer core of the interrupt block:
 *   free-running 64-bit mtime with register writes,
 *   64-bit mtimecmp and the msip bit,
 *   armed flag and one-cycle timer interrupt pulse,
 *   software interrupt level
 */
`include "clint_config.svh"

module clint_timer import clint_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      tick,
	input  reg_wr_t   wr,
	output reg_view_t view,
	output logic      irq,
	output logic      s_irq
);

	time_t mtime;
	time_t mtimecmp;
	time_t mtime_inc;
	logic  msip;
	logic  armed;
	logic  any_wr;
	logic  pending;

	// any mapped register write
	assign any_wr = wr.msip | wr.cmp_lo | wr.cmp_hi | wr.time_lo | wr.time_hi;

	// timer plus one on a tick, carry runs into the high word
	assign mtime_inc = mtime + {63'd0, tick};

	// unsigned compare over the full 64 bits
	assign pending = (mtime >= mtimecmp);

	// mtime, a write to one word overrides the increment of that word only
	always_ff @(posedge clk) begin
		if (rst) begin
			mtime <= '0;
		end else begin
			if (wr.time_lo) begin
				mtime[31:0] <= wr.data;
			end else begin
				mtime[31:0] <= mtime_inc[31:0];
			end
			if (wr.time_hi) begin
				mtime[63:32] <= wr.data;
			end else begin
				mtime[63:32] <= mtime_inc[63:32];
			end
		end
	end

	// mtimecmp, written one half at a time
	always_ff @(posedge clk) begin
		if (rst) begin
			mtimecmp <= `CLINT_CMP_RESET;
		end else begin
			if (wr.cmp_lo) begin
				mtimecmp[31:0] <= wr.data;
			end
			if (wr.cmp_hi) begin
				mtimecmp[63:32] <= wr.data;
			end
		end
	end

	// software interrupt bit
	always_ff @(posedge clk) begin
		if (rst) begin
			msip <= 1'b0;
		end else if (wr.msip) begin
			msip <= wr.data[`CLINT_MSIP_BIT];
		end
	end

	// arming and pulse generation
	// a write arms and holds irq low, firing disarms
	always_ff @(posedge clk) begin
		if (rst) begin
			armed <= 1'b0;
			irq   <= 1'b0;
		end else if (any_wr) begin
			armed <= 1'b1;
			irq   <= 1'b0;
		end else if (pending && armed) begin
			armed <= 1'b0;
			irq   <= 1'b1;
		end else begin
			irq <= 1'b0;
		end
	end

	// level output straight from the register
	assign s_irq = msip;

	// register contents back to the bus side
	assign view.mtime    = mtime;
	assign view.mtimecmp = mtimecmp;
	assign view.msip     = msip;

endmodule

//--- clint_tick_gen.sv
/*
 * Timer prescaler.
 * Divides the system clock down to the timer rate and
 * emits a one-cycle tick once per period.
 */
`include "clint_config.svh"

module clint_tick_gen (
	input  logic clk,
	input  logic rst,
	output logic tick
);

	// clock cycles per timer tick, 6 with the default settings
	localparam int unsigned DIVISOR = `CLINT_CLOCK_FREQ / `CLINT_TIMER_RATE;
	localparam logic [3:0] LAST = 4'(DIVISOR - 1);

	logic [3:0] cnt;

	// tick on the last count of the period
	assign tick = (cnt == LAST);

	// modulo counter, wraps after the tick
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (tick) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 4'd1;
		end
	end

endmodule

//--- clint_pkg.sv
/*
 * Shared types of the core-local interrupt block:
 *   word, offset and timer value typedefs,
 *   APB request and response structs,
 *   register write bundle (slave to timer),
 *   register view bundle (timer to slave)
 */
package clint_pkg;

	// bus and register word
	typedef logic [31:0] word_t;

	// register offset within the block
	typedef logic [15:0] ofs_t;

	// machine timer and compare value
	typedef logic [63:0] time_t;

	// master to slave
	typedef struct packed {
		logic  psel;
		logic  penable;
		logic  pwrite;
		ofs_t  paddr;
		word_t pwdata;
	} apb_req_t;

	// slave to master
	typedef struct packed {
		word_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	// one-hot write strobes, data already in register byte order
	typedef struct packed {
		logic  msip;
		logic  cmp_lo;
		logic  cmp_hi;
		logic  time_lo;
		logic  time_hi;
		word_t data;
	} reg_wr_t;

	// register contents seen by the read mux
	typedef struct packed {
		time_t mtime;
		time_t mtimecmp;
		logic  msip;
	} reg_view_t;

endpackage

//--- clint_config.svh
/*
 * Build-time settings of the core-local interrupt block:
 *   clock frequency and timer rate that set the tick divisor,
 *   APB offsets of the five registers,
 *   bit position of the software interrupt in register order,
 *   reset value of the timer compare register
 */
`ifndef CLINT_CONFIG_SVH
`define CLINT_CONFIG_SVH

// system clock and timer rate in hertz
`define CLINT_CLOCK_FREQ 62500000
`define CLINT_TIMER_RATE 10000000

// register offsets on the 16-bit APB space
`define CLINT_MSIP_OFS   16'h0000
`define CLINT_CMPL_OFS   16'h4000
`define CLINT_CMPH_OFS   16'h4004
`define CLINT_MTIMEL_OFS 16'hBFF8
`define CLINT_MTIMEH_OFS 16'hBFFC

// bus bit 0 of the msip word lands here after the byte swap
`define CLINT_MSIP_BIT 24

// compare starts out of reach so nothing fires before software sets it
`define CLINT_CMP_RESET 64'hFFFF_FFFF_FFFF_FFFF

`endif
